// File: hw/fetch_pkg.sv
package fetch_pkg;

    // conditional branch kinds resolved in this stage
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_beq  = 3'd1,
        br_bne  = 3'd2,
        br_blez = 3'd3,
        br_bgtz = 3'd4,
        br_bltz = 3'd5,
        br_bgez = 3'd6
    } branch_type_e;

    // next pc sources
    typedef enum logic [2:0] {
        sel_seq    = 3'd0,  // pc + 4
        sel_jump   = 3'd1,  // j / jal target
        sel_epc    = 3'd2,  // eret
        sel_exc    = 3'd3,  // exception entry
        sel_branch = 3'd4,
        sel_jreg   = 3'd5   // jr / jalr
    } pc_sel_e;

    // icache refill fsm
    typedef enum logic [1:0] {
        st_idle        = 2'd0,
        st_refill_req  = 2'd1,
        st_refill_wait = 2'd2,
        st_fill        = 2'd3
    } icache_state_e;

    localparam logic [31:0] RESET_PC = 32'hbfc0_0000; // boot rom, kseg1

endpackage

// File: hw/pc_reg.sv
module pc_reg (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pc_wr,
    input  logic        stall,   // icache refill in progress
    input  logic [31:0] next_pc,
    output logic [31:0] pc
);

    logic load;

    // hazard unit and cache must both agree
    assign load = pc_wr && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= fetch_pkg::RESET_PC;
        end else if (load) begin
            pc <= next_pc;
        end
    end

endmodule

// File: hw/npc_select.sv
module npc_select (
    input  logic                    [31:0] pc,
    input  logic                           exc_valid,
    input  logic                    [31:0] exc_vector,
    input  logic                           eret_valid,
    input  logic                    [31:0] epc,
    input  fetch_pkg::branch_type_e        exe_branch_type,
    input  logic                    [31:0] exe_pc,
    input  logic                    [31:0] exe_imm,
    input  logic                    [31:0] exe_rs_value,
    input  logic                    [31:0] exe_rt_value,
    input  logic                           exe_jreg,
    input  logic                           id_jump,
    input  logic                    [31:0] id_pc,
    input  logic                    [31:0] id_instr,
    output logic                    [31:0] next_pc
);

    fetch_pkg::pc_sel_e pc_sel;

    logic [31:0] pc_add4;
    logic [31:0] id_pc_add4;
    logic [31:0] jump_addr;
    logic [31:0] branch_addr;
    logic        rs_neg;
    logic        rs_zero;
    logic        branch_taken;

    assign pc_add4     = pc + 32'd4;
    assign id_pc_add4  = id_pc + 32'd4;
    assign jump_addr   = {id_pc_add4[31:28], id_instr[25:0], 2'b00}; // stays in 256MB region
    assign branch_addr = exe_pc + 32'd4 + {exe_imm[29:0], 2'b00};

    // sign and zero tests cover the signed compares against zero
    assign rs_neg  = exe_rs_value[31];
    assign rs_zero = (exe_rs_value == 32'd0);

    always_comb begin
        case (exe_branch_type)
            fetch_pkg::br_beq:  branch_taken = (exe_rs_value == exe_rt_value);
            fetch_pkg::br_bne:  branch_taken = (exe_rs_value != exe_rt_value);
            fetch_pkg::br_blez: branch_taken = rs_neg || rs_zero;
            fetch_pkg::br_bgtz: branch_taken = !rs_neg && !rs_zero;
            fetch_pkg::br_bltz: branch_taken = rs_neg;
            fetch_pkg::br_bgez: branch_taken = !rs_neg;
            default:            branch_taken = 1'b0;
        endcase
    end

    // fixed priority, oldest pipeline stage wins
    always_comb begin
        if (exc_valid) begin
            pc_sel = fetch_pkg::sel_exc;
        end else if (eret_valid) begin
            pc_sel = fetch_pkg::sel_epc;
        end else if (branch_taken) begin
            pc_sel = fetch_pkg::sel_branch;
        end else if (exe_jreg) begin
            pc_sel = fetch_pkg::sel_jreg;
        end else if (id_jump) begin
            pc_sel = fetch_pkg::sel_jump;
        end else begin
            pc_sel = fetch_pkg::sel_seq;
        end
    end

    always_comb begin
        case (pc_sel)
            fetch_pkg::sel_exc:    next_pc = exc_vector;
            fetch_pkg::sel_epc:    next_pc = epc;
            fetch_pkg::sel_branch: next_pc = branch_addr;
            fetch_pkg::sel_jreg:   next_pc = exe_rs_value;
            fetch_pkg::sel_jump:   next_pc = jump_addr;
            default:               next_pc = pc_add4;
        endcase
    end

endmodule

// File: hw/icache.sv
module icache #(
    parameter int LINE_WORDS = 4,
    parameter int LINES      = 64
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] pc,
    input  logic        lookup,
    output logic        busy,
    output logic        instr_valid,
    output logic [31:0] instr,
    output logic [31:0] instr_pc,
    output logic        refill_req,
    output logic [31:0] refill_addr,
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata
);

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

    fetch_pkg::icache_state_e state;

    // storage
    logic [TAG_W-1:0] tag_arr  [LINES];
    logic [31:0]      data_arr [LINES][LINE_WORDS];
    logic [LINES-1:0] valid_q;

    // incoming pc fields, tag is compared one cycle later
    logic [IDX_W-1:0] pc_idx;
    logic [OFF_W-1:0] pc_off;

    // second stage of the lookup
    logic             req_vld;
    logic [31:0]      req_pc;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] req_idx;
    logic [OFF_W-1:0] req_off;
    logic             rd_valid;
    logic [TAG_W-1:0] rd_tag;
    logic [31:0]      rd_data;

    logic             hit;
    logic             miss;
    logic             collecting;
    logic             last_word;
    logic [OFF_W-1:0] word_cnt;
    logic [31:0]      line_buf [LINE_WORDS];

    assign {pc_idx, pc_off}            = pc[IDX_W+OFF_W+1:2];
    assign {req_tag, req_idx, req_off} = req_pc[31:2];

    // req_vld only set while idle
    assign hit  = req_vld && rd_valid && (rd_tag == req_tag);
    assign miss = req_vld && !hit;

    // miss must stall the pc in the same cycle, else the next pc slips past
    assign busy        = (state != fetch_pkg::st_idle) || miss;
    assign instr_valid = hit;
    assign instr       = rd_data;
    assign instr_pc    = req_pc;

    assign refill_req  = (state == fetch_pkg::st_refill_req);
    assign refill_addr = {req_pc[31:OFF_W+2], {(OFF_W+2){1'b0}}};

    // memory may start answering right after the strobe
    assign collecting = (state == fetch_pkg::st_refill_req) ||
                        (state == fetch_pkg::st_refill_wait);
    assign last_word  = mem_rvalid && (word_cnt == OFF_W'(LINE_WORDS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= fetch_pkg::st_idle;
            word_cnt <= '0;
        end else begin
            case (state)
                fetch_pkg::st_idle: begin
                    if (miss) begin
                        state <= fetch_pkg::st_refill_req;
                    end
                end
                fetch_pkg::st_refill_req: begin
                    state <= fetch_pkg::st_refill_wait;
                end
                fetch_pkg::st_refill_wait: begin
                    if (last_word) begin
                        state <= fetch_pkg::st_fill;
                    end
                end
                default: state <= fetch_pkg::st_idle; // st_fill, one cycle
            endcase
            if (collecting && mem_rvalid) begin
                word_cnt <= word_cnt + 1'b1; // wraps to zero on the last word
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_vld  <= 1'b0;
            rd_valid <= 1'b0;
        end else if (state == fetch_pkg::st_fill) begin
            req_vld  <= 1'b1; // replay the missed pc
            rd_valid <= 1'b1;
        end else begin
            req_vld  <= lookup;
            rd_valid <= valid_q[pc_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_pkg::st_fill) begin
            // arrays are written this edge, so read from the line buffer
            rd_tag  <= req_tag;
            rd_data <= line_buf[req_off];
        end else if (lookup) begin
            req_pc  <= pc;
            rd_tag  <= tag_arr[pc_idx];
            rd_data <= data_arr[pc_idx][pc_off];
        end
        if (collecting && mem_rvalid) begin
            line_buf[word_cnt] <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_pkg::st_fill) begin
            tag_arr[req_idx] <= req_tag;
            for (int w = 0; w < LINE_WORDS; w++) begin
                data_arr[req_idx][w] <= line_buf[w];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (state == fetch_pkg::st_fill) begin
            valid_q[req_idx] <= 1'b1;
        end
    end

endmodule

// File: hw/fetch_front.sv
module fetch_front #(
    parameter int LINE_WORDS = 4,
    parameter int LINES      = 64
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           pc_wr,

    // redirects, held until the pc loads
    input  logic                           exc_valid,
    input  logic                    [31:0] exc_vector,
    input  logic                           eret_valid,
    input  logic                    [31:0] epc,
    input  fetch_pkg::branch_type_e        exe_branch_type,
    input  logic                    [31:0] exe_pc,
    input  logic                    [31:0] exe_imm,
    input  logic                    [31:0] exe_rs_value,
    input  logic                    [31:0] exe_rt_value,
    input  logic                           exe_jreg,
    input  logic                           id_jump,
    input  logic                    [31:0] id_pc,
    input  logic                    [31:0] id_instr,

    output logic                           instr_valid,
    output logic                    [31:0] instr,
    output logic                    [31:0] instr_pc,
    output logic                           busy,

    // refill side
    output logic                           refill_req,
    output logic                    [31:0] refill_addr,
    input  logic                           mem_rvalid,
    input  logic                    [31:0] mem_rdata
);

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        lookup;

    assign lookup = pc_wr && !busy; // same condition that loads the pc

    pc_reg u_pc_reg (
        .clk     (clk),
        .arst_n  (arst_n),
        .pc_wr   (pc_wr),
        .stall   (busy),
        .next_pc (next_pc),
        .pc      (pc)
    );

    npc_select u_npc_select (
        .pc              (pc),
        .exc_valid       (exc_valid),
        .exc_vector      (exc_vector),
        .eret_valid      (eret_valid),
        .epc             (epc),
        .exe_branch_type (exe_branch_type),
        .exe_pc          (exe_pc),
        .exe_imm         (exe_imm),
        .exe_rs_value    (exe_rs_value),
        .exe_rt_value    (exe_rt_value),
        .exe_jreg        (exe_jreg),
        .id_jump         (id_jump),
        .id_pc           (id_pc),
        .id_instr        (id_instr),
        .next_pc         (next_pc)
    );

    icache #(
        .LINE_WORDS (LINE_WORDS),
        .LINES      (LINES)
    ) u_icache (
        .clk         (clk),
        .arst_n      (arst_n),
        .pc          (pc),
        .lookup      (lookup),
        .busy        (busy),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

endmodule

// File: testbench/tb_refill_mem.sv
module tb_refill_mem #(
    parameter int LINE_WORDS = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        refill_req,
    input  logic [31:0] refill_addr,
    output logic        mem_rvalid,
    output logic [31:0] mem_rdata
);

    integer      seed = 32'h2b00_bfce;
    logic        active;
    logic [31:0] base;
    int          wait_cnt;
    int          word_idx;
    int          gap;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active     <= 1'b0;
            base       <= '0;
            wait_cnt   <= 0;
            word_idx   <= 0;
            gap        <= 0;
            mem_rvalid <= 1'b0;
            mem_rdata  <= '0;
        end else begin
            mem_rvalid <= 1'b0; // strobe, one cycle only
            if (refill_req) begin
                active   <= 1'b1;
                base     <= refill_addr;
                wait_cnt <= 2;  // first word 3 cycles after the request
                word_idx <= 0;
                gap      <= 0;
            end else if (active) begin
                if (wait_cnt > 0) begin
                    wait_cnt <= wait_cnt - 1;
                end else if (gap > 0) begin
                    gap <= gap - 1;
                end else begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= (base + 32'(word_idx) * 32'd4) ^ 32'h5a5a_0000;
                    gap        <= $random(seed) & 1; // 0 or 1 idle cycles
                    if (word_idx == LINE_WORDS - 1) begin
                        active <= 1'b0;
                    end else begin
                        word_idx <= word_idx + 1;
                    end
                end
            end
        end
    end

endmodule

// File: testbench/fetch_front_assert.sv
module fetch_front_assert #(
    parameter int LINE_WORDS = 4
) (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic instr_valid,
    input logic refill_req,
    input logic mem_rvalid
);

    logic in_refill; // from refill_req up to the last word
    int   rv_cnt;
    int   err_cnt = 0; // failed assertions so far

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_refill <= 1'b0;
            rv_cnt    <= 0;
        end else if (refill_req) begin
            in_refill <= 1'b1;
            rv_cnt    <= 0;
        end else if (in_refill && mem_rvalid) begin
            rv_cnt <= rv_cnt + 1;
            if (rv_cnt == LINE_WORDS - 1) begin
                in_refill <= 1'b0;
            end
        end
    end

    no_double_req: assert property (@(posedge clk) disable iff (!arst_n)
        refill_req |=> !refill_req)
        else begin
            $error("refill_req high in two consecutive cycles");
            err_cnt++;
        end

    no_valid_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        !(instr_valid && busy))
        else begin
            $error("instr_valid while busy");
            err_cnt++;
        end

    busy_during_refill: assert property (@(posedge clk) disable iff (!arst_n)
        in_refill |-> busy)
        else begin
            $error("busy dropped before the last refill word");
            err_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!busy && !refill_req))
        else begin
            $error("busy or refill_req set during reset");
            err_cnt++;
        end

endmodule

bind icache fetch_front_assert #(
    .LINE_WORDS (LINE_WORDS)
) u_fetch_front_assert (
    .clk         (clk),
    .arst_n      (arst_n),
    .busy        (busy),
    .instr_valid (instr_valid),
    .refill_req  (refill_req),
    .mem_rvalid  (mem_rvalid)
);

// File: testbench/tb_fetch_front.sv
module tb_fetch_front;

    localparam int          LINE_WORDS = 4;
    localparam int          LINES      = 64;
    localparam int          REC_W      = 10;  // words per record in the data file
    localparam int          REC_MAX    = 64;
    localparam logic [31:0] DATA_KEY   = 32'h5a5a_0000;

    logic                    clk;
    logic                    arst_n;
    logic                    pc_wr;
    logic                    exc_valid;
    logic [31:0]             exc_vector;
    logic                    eret_valid;
    logic [31:0]             epc;
    fetch_pkg::branch_type_e exe_branch_type;
    logic [31:0]             exe_pc;
    logic [31:0]             exe_imm;
    logic [31:0]             exe_rs_value;
    logic [31:0]             exe_rt_value;
    logic                    exe_jreg;
    logic                    id_jump;
    logic [31:0]             id_pc;
    logic [31:0]             id_instr;
    logic                    instr_valid;
    logic [31:0]             instr;
    logic [31:0]             instr_pc;
    logic                    busy;
    logic                    refill_req;
    logic [31:0]             refill_addr;
    logic                    mem_rvalid;
    logic [31:0]             mem_rdata;

    logic [31:0]             stim [0:REC_MAX*REC_W-1];
    logic [31:0]             exp_pc [0:REC_MAX];
    fetch_pkg::branch_type_e exp_br [0:REC_MAX]; // branch in force for each target
    bit                      refilled [logic [31:0]];
    int          ncmd;
    int          exp_cnt;
    int          rcv_cnt;
    int          errors;
    int          err_before;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int          limit;

    fetch_front #(
        .LINE_WORDS (LINE_WORDS),
        .LINES      (LINES)
    ) u_fetch_front (
        .clk             (clk),
        .arst_n          (arst_n),
        .pc_wr           (pc_wr),
        .exc_valid       (exc_valid),
        .exc_vector      (exc_vector),
        .eret_valid      (eret_valid),
        .epc             (epc),
        .exe_branch_type (exe_branch_type),
        .exe_pc          (exe_pc),
        .exe_imm         (exe_imm),
        .exe_rs_value    (exe_rs_value),
        .exe_rt_value    (exe_rt_value),
        .exe_jreg        (exe_jreg),
        .id_jump         (id_jump),
        .id_pc           (id_pc),
        .id_instr        (id_instr),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .instr_pc        (instr_pc),
        .busy            (busy),
        .refill_req      (refill_req),
        .refill_addr     (refill_addr),
        .mem_rvalid      (mem_rvalid),
        .mem_rdata       (mem_rdata)
    );

    tb_refill_mem #(
        .LINE_WORDS (LINE_WORDS)
    ) u_refill_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_pc(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error instr_pc expected %h actual %h", exp, act);
            errors++;
        end
    endtask

    task automatic check_instr(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error instr expected %h actual %h", exp, act);
            errors++;
        end
    endtask

    task automatic check_branch(input fetch_pkg::branch_type_e br,
                                input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error instr_pc expected %h actual %h (in force %s)",
                     exp, act, br.name());
            errors++;
        end
    endtask

    // called on a rising edge, returns on the edge that loads the pc
    task automatic apply_record(input int r);
        logic [31:0]             ctrl;
        fetch_pkg::branch_type_e br;
        int                      idle;
        ctrl = stim[r*REC_W];
        br   = fetch_pkg::branch_type_e'(ctrl[2:0]);
        idle = int'(ctrl[15:8]);
        if (idle > 0) begin
            pc_wr <= 1'b0;
            repeat (idle) @(posedge clk);
        end
        exc_valid       <= ctrl[4];
        eret_valid      <= ctrl[5];
        exe_jreg        <= ctrl[6];
        id_jump         <= ctrl[7];
        exe_branch_type <= br;
        exc_vector      <= stim[r*REC_W+1];
        epc             <= stim[r*REC_W+2];
        exe_pc          <= stim[r*REC_W+3];
        exe_imm         <= stim[r*REC_W+4];
        exe_rs_value    <= stim[r*REC_W+5];
        exe_rt_value    <= stim[r*REC_W+6];
        id_pc           <= stim[r*REC_W+7];
        id_instr        <= stim[r*REC_W+8];
        pc_wr           <= 1'b1;
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic clear_redirects();
        exc_valid       <= 1'b0;
        exc_vector      <= '0;
        eret_valid      <= 1'b0;
        epc             <= '0;
        exe_branch_type <= fetch_pkg::br_none;
        exe_pc          <= '0;
        exe_imm         <= '0;
        exe_rs_value    <= '0;
        exe_rt_value    <= '0;
        exe_jreg        <= 1'b0;
        id_jump         <= 1'b0;
        id_pc           <= '0;
        id_instr        <= '0;
    endtask

    // output side, sampled away from the driving edge
    always @(negedge clk) begin
        if (arst_n && instr_valid) begin
            if (rcv_cnt >= exp_cnt) begin
                $display("unexpected instruction for pc %h after the last test", instr_pc);
                errors++;
            end else begin
                err_before = errors;
                if (exp_br[rcv_cnt] != fetch_pkg::br_none) begin
                    check_branch(exp_br[rcv_cnt], exp_pc[rcv_cnt], instr_pc);
                end else begin
                    check_pc(exp_pc[rcv_cnt], instr_pc);
                end
                check_instr(exp_pc[rcv_cnt] ^ DATA_KEY, instr);
                if (errors == err_before) begin
                    pass_cnt++;
                    $display("test %0d pc %h passed", rcv_cnt, exp_pc[rcv_cnt]);
                end else begin
                    fail_cnt++;
                    $display("test %0d pc %h failed", rcv_cnt, exp_pc[rcv_cnt]);
                end
                rcv_cnt++;
            end
        end
        if (arst_n && refill_req) begin
            if (refilled.exists(refill_addr)) begin
                $display("line %h refilled again although it is cached", refill_addr);
                errors++;
            end else begin
                refilled[refill_addr] = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit > 0 && cycle_cnt >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d instructions seen",
                     cycle_cnt, rcv_cnt, exp_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        arst_n    <= 1'b0;
        pc_wr     <= 1'b0;
        clear_redirects();
        ncmd      = 0;
        rcv_cnt   = 0;
        errors    = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        cycle_cnt = 0;
        limit     = 0;
        exp_cnt   = 1;
        exp_pc[0] = fetch_pkg::RESET_PC;
        exp_br[0] = fetch_pkg::br_none;

        $readmemh("testbench/fetch_input.txt", stim);
        while (ncmd < REC_MAX && stim[ncmd*REC_W] !== 32'hffff_ffff) begin
            exp_pc[ncmd+1] = stim[ncmd*REC_W+9];
            exp_br[ncmd+1] = fetch_pkg::branch_type_e'(stim[ncmd*REC_W][2:0]);
            ncmd++;
        end
        exp_cnt = ncmd + 1;
        limit   = exp_cnt * (LINE_WORDS * 2 + 10);

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        for (int r = 0; r < ncmd; r++) begin
            apply_record(r);
        end

        // one more sequential step so the last target gets fetched
        clear_redirects();
        pc_wr <= 1'b1;
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        pc_wr <= 1'b0;

        while (rcv_cnt < exp_cnt) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("tests %0d passed %0d failed %0d errors %0d",
                 rcv_cnt, pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0 && rcv_cnt == exp_cnt &&
            u_fetch_front.u_icache.u_fetch_front_assert.err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
hw/fetch_pkg.sv
hw/pc_reg.sv
hw/npc_select.sv
hw/icache.sv
hw/fetch_front.sv
testbench/tb_refill_mem.sv
testbench/fetch_front_assert.sv
testbench/tb_fetch_front.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_fetch_front
FILELIST  = project.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the grep result is the exit status of the run
run: compile
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/fetch_input.txt
// ctrl exc_vector epc exe_pc exe_imm rs rt id_pc id_instr expected_next_pc
// ctrl: [2:0] branch type, [4] exc, [5] eret, [6] jreg, [7] jump, [15:8] idle cycles
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00004
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00008
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc0000c
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00010
00000300 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00014
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00018
00000080 00000000 00000000 00000000 00000000 00000000 00000000 bfc00014 0bf00000 bfc00000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00004
00000040 00000000 00000000 00000000 00000000 bfc00020 00000000 00000000 00000000 bfc00020
00000001 00000000 00000000 bfc00020 00000010 00000005 00000005 00000000 00000000 bfc00064
00000001 00000000 00000000 bfc00020 00000010 00000005 00000006 00000000 00000000 bfc00068
00000002 00000000 00000000 bfc00068 fffffff8 00000001 00000002 00000000 00000000 bfc0004c
00000002 00000000 00000000 bfc00068 fffffff8 00000007 00000007 00000000 00000000 bfc00050
00000003 00000000 00000000 bfc00050 00000004 00000000 00000000 00000000 00000000 bfc00064
00000003 00000000 00000000 bfc00050 00000004 00000001 00000000 00000000 00000000 bfc00068
00000004 00000000 00000000 bfc00100 00000003 00000001 00000000 00000000 00000000 bfc00110
00000004 00000000 00000000 bfc00100 00000003 80000000 00000000 00000000 00000000 bfc00114
00000005 00000000 00000000 bfc00114 fffffffb ffffffff 00000000 00000000 00000000 bfc00104
00000005 00000000 00000000 bfc00114 fffffffb 00000000 00000000 00000000 00000000 bfc00108
00000006 00000000 00000000 bfc00108 00000002 00000000 00000000 00000000 00000000 bfc00114
00000006 00000000 00000000 bfc00108 00000002 80000001 00000000 00000000 00000000 bfc00118
00000031 bfc00380 bfc00200 bfc00118 00000004 00000009 00000009 00000000 00000000 bfc00380
00000021 bfc00380 bfc00200 bfc00118 00000004 00000009 00000009 00000000 00000000 bfc00200
00000011 bfc00380 bfc00200 bfc00118 00000004 00000009 00000009 00000000 00000000 bfc00380
000000e0 00000000 bfc00240 00000000 00000000 bfc00300 00000000 bfc00014 0bf00000 bfc00240
00000041 00000000 00000000 bfc00240 00000002 bfc00300 bfc00300 00000000 00000000 bfc0024c
00000042 00000000 00000000 bfc00240 00000002 bfc00300 bfc00300 00000000 00000000 bfc00300
00000200 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00304
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 bfc00308
ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
